// ==== hdl/npu_cmd_fifo.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_cmd_fifo
    import npu_pkg::*;
(
    input  logic      CLOCK_50,
    input  logic      reset,
    input  logic      in_valid,
    output logic      in_ready,
    input  npu_inst_u in_word,
    output logic      out_valid,
    input  logic      out_ready,
    output npu_inst_u out_word,
    output logic      empty
);
    localparam int DEPTH = `NPU_FIFO_DEPTH;
    localparam int PW    = $clog2(DEPTH);

    npu_inst_u     slots [DEPTH];
    logic [PW-1:0] wr_ptr;
    logic [PW-1:0] rd_ptr;
    logic [PW:0]   count;
    logic          push;
    logic          pop;

    assign in_ready  = count != DEPTH;
    assign out_valid = count != '0;
    assign empty     = count == '0;
    assign out_word  = slots[rd_ptr];
    assign push      = in_valid && in_ready;
    assign pop       = out_valid && out_ready;

    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count <= count + push - pop;
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (push) begin
            slots[wr_ptr] <= in_word;
        end
    end

    // full queue holds its write pointer while the producer waits
    assert property (@(posedge CLOCK_50) disable iff (reset)
        (in_valid && count == DEPTH) |-> (wr_ptr == rd_ptr) ##1 (wr_ptr == $past(wr_ptr)))
        else $error("command queue accepted a push while full");

endmodule

// ==== hdl/npu_data_mem.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_data_mem (
    input  logic       CLOCK_50,
    npu_mem_if.memory  host_mem,
    npu_mem_if.memory  eng_mem
);
    localparam int NBANK = 1 << `NPU_BANK_W;
    localparam int NWORD = 1 << `NPU_OFFS_W;

    logic                   req;
    logic                   we;
    logic [`NPU_ADDR_W-1:0] addr;
    logic [`NPU_DATA_W-1:0] wdata;
    logic [`NPU_BANK_W-1:0] bank_sel;
    logic [`NPU_OFFS_W-1:0] offs;
    logic [`NPU_BANK_W-1:0] host_bank_q;
    logic [`NPU_BANK_W-1:0] eng_bank_q;
    logic [`NPU_DATA_W-1:0] bank_rd [NBANK];

    // engine takes the port first
    assign req      = eng_mem.req || host_mem.req;
    assign we       = eng_mem.req ? eng_mem.we : host_mem.we;
    assign addr     = eng_mem.req ? eng_mem.addr : host_mem.addr;
    assign wdata    = eng_mem.req ? eng_mem.wdata : host_mem.wdata;
    assign bank_sel = addr[`NPU_ADDR_W-1 -: `NPU_BANK_W];
    assign offs     = addr[`NPU_OFFS_W-1:0];

    for (genvar b = 0; b < NBANK; b++) begin : g_bank
        logic [`NPU_DATA_W-1:0] words [NWORD];
        logic [`NPU_DATA_W-1:0] rd_q;

        always_ff @(posedge CLOCK_50) begin
            if (req && bank_sel == b) begin
                if (we) begin
                    words[offs] <= wdata;
                end
                rd_q <= words[offs];
            end
        end

        assign bank_rd[b] = rd_q;
    end

    // remember which bank each port read from
    always_ff @(posedge CLOCK_50) begin
        if (eng_mem.req) begin
            eng_bank_q <= bank_sel;
        end else if (host_mem.req) begin
            host_bank_q <= bank_sel;
        end
    end

    assign host_mem.rdata = bank_rd[host_bank_q];
    assign eng_mem.rdata  = bank_rd[eng_bank_q];

    // host only gets the port while the engine is idle
    assert property (@(posedge CLOCK_50)
        !(host_mem.req === 1'b1 && eng_mem.req === 1'b1))
        else $error("host and engine requested memory in the same cycle");

endmodule

// ==== hdl/npu_defs.svh ====
`ifndef NPU_DEFS_SVH
`define NPU_DEFS_SVH

// datapath widths
`define NPU_DATA_W        16
`define NPU_ADDR_W        10
`define NPU_BANK_W        2
`define NPU_OFFS_W        8
`define NPU_INST_W        64
`define NPU_DIM_W         4

// opcodes
`define NPU_OP_ADD        4'h1
`define NPU_OP_POOL       4'h8

// command queue
`define NPU_FIFO_DEPTH    4

// apb word address map
`define NPU_APB_DATA_BASE 12'h000
`define NPU_APB_INST_LO   12'h800
`define NPU_APB_INST_HI   12'h801
`define NPU_APB_STATUS    12'h802

`endif

// ==== hdl/npu_host_port.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_host_port
    import npu_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         reset,
    input  logic         psel,
    input  logic         penable,
    input  logic         pwrite,
    input  logic [11:0]  paddr,
    input  logic [31:0]  pwdata,
    output logic [31:0]  prdata,
    output logic         pready,
    output logic         pslverr,
    npu_mem_if.requester host_mem,
    output logic         cmd_valid,
    input  logic         cmd_ready,
    output npu_inst_u    cmd_word,
    input  logic         fifo_empty,
    input  logic         engine_busy
);
    logic                   access;
    logic                   sel_data;
    logic                   sel_lo;
    logic                   sel_hi;
    logic                   sel_stat;
    logic                   sys_busy;
    logic                   inst_ok;
    logic [`NPU_INST_W-1:0] inst_bits;
    npu_inst_u              inst;
    logic [31:0]            inst_lo_q;
    logic                   reject_q;
    logic                   busy_q;
    logic                   rd_pend_q;
    logic [3:0]             done_cnt_q;

    // --------------------------------------------------------------------------
    // address decode
    // --------------------------------------------------------------------------
    assign access   = psel && penable;
    assign sel_data = (paddr & 12'hC00) == `NPU_APB_DATA_BASE;
    assign sel_lo   = paddr == `NPU_APB_INST_LO;
    assign sel_hi   = paddr == `NPU_APB_INST_HI;
    assign sel_stat = paddr == `NPU_APB_STATUS;
    assign pslverr  = access && !(sel_data || sel_lo || sel_hi || sel_stat);

    // queued or running work blocks the data window
    assign sys_busy = !fifo_empty || engine_busy;

    // --------------------------------------------------------------------------
    // instruction check
    // --------------------------------------------------------------------------
    assign inst_bits = {pwdata, inst_lo_q};
    assign inst      = inst_bits;

    always_comb begin
        case (inst.add.opcode)
            `NPU_OP_ADD:
                inst_ok = (inst.add.rows != '0) && (inst.add.cols != '0);
            `NPU_OP_POOL:
                inst_ok = (inst.pool.rows != '0) && (inst.pool.cols != '0)
                    && (inst.pool.win_rows != '0) && (inst.pool.win_cols != '0)
                    && (inst.pool.win_rows <= 4'd3) && (inst.pool.win_cols <= 4'd3)
                    && (inst.pool.win_rows <= inst.pool.rows)
                    && (inst.pool.win_cols <= inst.pool.cols);
            default:
                inst_ok = 1'b0;
        endcase
    end

    assign cmd_word  = inst;
    assign cmd_valid = access && pwrite && sel_hi && inst_ok;

    // --------------------------------------------------------------------------
    // data window and apb response
    // --------------------------------------------------------------------------
    assign host_mem.req   = access && sel_data && !sys_busy && !rd_pend_q;
    assign host_mem.we    = pwrite;
    assign host_mem.addr  = paddr[`NPU_ADDR_W-1:0];
    assign host_mem.wdata = pwdata[`NPU_DATA_W-1:0];

    always_comb begin
        pready = 1'b0;
        if (access) begin
            if (sel_data) begin
                // reads finish once the registered data is back
                pready = pwrite ? !sys_busy : rd_pend_q;
            end else if (sel_hi && pwrite) begin
                pready = !inst_ok || cmd_ready;
            end else begin
                pready = 1'b1;
            end
        end
    end

    always_comb begin
        prdata = '0;
        if (sel_data) begin
            prdata = {{(32 - `NPU_DATA_W){1'b0}}, host_mem.rdata};
        end else if (sel_lo) begin
            prdata = inst_lo_q;
        end else if (sel_stat) begin
            prdata = {24'b0, done_cnt_q, 2'b0, reject_q, sys_busy};
        end
    end

    // --------------------------------------------------------------------------
    // status and staging registers
    // --------------------------------------------------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            reject_q   <= 1'b0;
            busy_q     <= 1'b0;
            rd_pend_q  <= 1'b0;
            done_cnt_q <= '0;
        end else begin
            busy_q    <= engine_busy;
            rd_pend_q <= host_mem.req && !pwrite;
            // one completion per falling edge of engine busy
            if (busy_q && !engine_busy) begin
                done_cnt_q <= done_cnt_q + 1'b1;
            end
            if (access && pwrite && sel_hi && !inst_ok) begin
                reject_q <= 1'b1;
            end else if (access && pwrite && sel_stat && pwdata[1]) begin
                reject_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge CLOCK_50) begin
        if (access && pwrite && sel_lo) begin
            inst_lo_q <= pwdata;
        end
    end

endmodule

// ==== hdl/npu_matrix_engine.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_matrix_engine
    import npu_pkg::*;
(
    input  logic         CLOCK_50,
    input  logic         reset,
    input  logic         cmd_valid,
    output logic         cmd_ready,
    input  npu_inst_u    cmd_word,
    npu_mem_if.requester eng_mem,
    output logic         busy
);
    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_ADD_RD1 = 3'd1;
    localparam logic [2:0] S_ADD_RD2 = 3'd2;
    localparam logic [2:0] S_ADD_WR  = 3'd3;
    localparam logic [2:0] S_POOL_RD = 3'd4;
    localparam logic [2:0] S_POOL_WR = 3'd5;

    logic [2:0]               state;
    npu_inst_u                cmd_q;
    logic [2*`NPU_DIM_W-1:0]  dst_q;
    logic [2*`NPU_DIM_W-1:0]  n_elem;
    logic [`NPU_DIM_W-1:0]    base_r;
    logic [`NPU_DIM_W-1:0]    base_c;
    logic [1:0]               wr_q;
    logic [1:0]               wc_q;
    logic [`NPU_DATA_W-1:0]   acc_q;
    logic [`NPU_DATA_W-1:0]   pool_max;
    logic                     rd_vld;
    logic [2*`NPU_DIM_W:0]    pool_offs;
    logic [`NPU_DIM_W+1:0]    next_c_end;
    logic [`NPU_DIM_W+1:0]    next_r_end;
    logic                     win_last;
    logic                     add_last;

    assign cmd_ready = state == S_IDLE;
    assign busy      = state != S_IDLE;

    // --------------------------------------------------------------------------
    // address arithmetic
    // --------------------------------------------------------------------------
    assign n_elem   = cmd_q.add.rows * cmd_q.add.cols;
    assign add_last = dst_q == n_elem - 1'b1;

    // source element of the window at (base_r + wr, base_c + wc)
    assign pool_offs  = (base_r + wr_q) * cmd_q.pool.cols + base_c + wc_q;
    assign next_c_end = base_c + cmd_q.pool.win_cols + cmd_q.pool.win_cols;
    assign next_r_end = base_r + cmd_q.pool.win_rows + cmd_q.pool.win_rows;
    assign win_last   = (wr_q == cmd_q.pool.win_rows - 1'b1)
                     && (wc_q == cmd_q.pool.win_cols - 1'b1);
    assign pool_max   = (eng_mem.rdata > acc_q) ? eng_mem.rdata : acc_q;

    always_comb begin
        eng_mem.req   = busy;
        eng_mem.we    = (state == S_ADD_WR) || (state == S_POOL_WR);
        eng_mem.wdata = (state == S_ADD_WR) ? acc_q + eng_mem.rdata : pool_max;
        case (state)
            S_ADD_RD1: eng_mem.addr = cmd_q.add.src1 + dst_q;
            S_ADD_RD2: eng_mem.addr = cmd_q.add.src2 + dst_q;
            S_ADD_WR:  eng_mem.addr = cmd_q.add.dest + dst_q;
            S_POOL_RD: eng_mem.addr = cmd_q.pool.src + pool_offs;
            default:   eng_mem.addr = cmd_q.pool.dest + dst_q;
        endcase
    end

    // --------------------------------------------------------------------------
    // sequencer
    // --------------------------------------------------------------------------
    always_ff @(posedge CLOCK_50) begin
        if (reset) begin
            state  <= S_IDLE;
            dst_q  <= '0;
            base_r <= '0;
            base_c <= '0;
            wr_q   <= '0;
            wc_q   <= '0;
            rd_vld <= 1'b0;
        end else begin
            rd_vld <= state == S_POOL_RD;
            case (state)
                S_IDLE: begin
                    dst_q  <= '0;
                    base_r <= '0;
                    base_c <= '0;
                    wr_q   <= '0;
                    wc_q   <= '0;
                    if (cmd_valid) begin
                        state <= (cmd_word.add.opcode == `NPU_OP_ADD) ? S_ADD_RD1 : S_POOL_RD;
                    end
                end
                S_ADD_RD1: state <= S_ADD_RD2;
                S_ADD_RD2: state <= S_ADD_WR;
                S_ADD_WR: begin
                    dst_q <= dst_q + 1'b1;
                    state <= add_last ? S_IDLE : S_ADD_RD1;
                end
                S_POOL_RD: begin
                    // scan the window row by row
                    if (win_last) begin
                        wr_q  <= '0;
                        wc_q  <= '0;
                        state <= S_POOL_WR;
                    end else if (wc_q == cmd_q.pool.win_cols - 1'b1) begin
                        wc_q <= '0;
                        wr_q <= wr_q + 1'b1;
                    end else begin
                        wc_q <= wc_q + 1'b1;
                    end
                end
                S_POOL_WR: begin
                    dst_q <= dst_q + 1'b1;
                    state <= S_POOL_RD;
                    // partial windows at the edge are skipped
                    if (next_c_end > cmd_q.pool.cols) begin
                        base_c <= '0;
                        base_r <= base_r + cmd_q.pool.win_rows;
                        if (next_r_end > cmd_q.pool.rows) begin
                            state <= S_IDLE;
                        end
                    end else begin
                        base_c <= base_c + cmd_q.pool.win_cols;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    // command and running result
    always_ff @(posedge CLOCK_50) begin
        if (cmd_ready && cmd_valid) begin
            cmd_q <= cmd_word;
        end
        if (state == S_ADD_RD2) begin
            acc_q <= eng_mem.rdata;
        end else if (state == S_POOL_RD && rd_vld) begin
            acc_q <= pool_max;
        end else if (state != S_POOL_RD) begin
            acc_q <= '0;
        end
    end

    // destination writes stay inside the running command
    assert property (@(posedge CLOCK_50) disable iff (reset)
        eng_mem.we |-> busy && (dst_q < n_elem))
        else $error("engine wrote memory outside a command");

endmodule

// ==== hdl/npu_mem_if.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

// one serial memory port, read data one cycle after the request
interface npu_mem_if;
    logic                   req;
    logic                   we;
    logic [`NPU_ADDR_W-1:0] addr;
    logic [`NPU_DATA_W-1:0] wdata;
    logic [`NPU_DATA_W-1:0] rdata;

    modport requester (output req, output we, output addr, output wdata, input rdata);
    modport memory (input req, input we, input addr, input wdata, output rdata);
endinterface

// ==== hdl/npu_pkg.sv ====
`include "npu_defs.svh"

package npu_pkg;

    // add instruction layout
    typedef struct packed {
        logic [3:0]              opcode;
        logic [`NPU_ADDR_W-1:0] src1;
        logic [`NPU_ADDR_W-1:0] src2;
        logic [`NPU_ADDR_W-1:0] dest;
        logic [`NPU_DIM_W-1:0]  rows;
        logic [`NPU_DIM_W-1:0]  cols;
        logic [21:0]             rsvd;
    } npu_add_fields_t;

    // pool instruction layout, window sits where add keeps src2
    typedef struct packed {
        logic [3:0]              opcode;
        logic [`NPU_ADDR_W-1:0] src;
        logic [`NPU_DIM_W-1:0]  win_rows;
        logic [`NPU_DIM_W-1:0]  win_cols;
        logic [1:0]              rsvd_win;
        logic [`NPU_ADDR_W-1:0] dest;
        logic [`NPU_DIM_W-1:0]  rows;
        logic [`NPU_DIM_W-1:0]  cols;
        logic [21:0]             rsvd;
    } npu_pool_fields_t;

    typedef union packed {
        npu_add_fields_t  add;
        npu_pool_fields_t pool;
    } npu_inst_u;

endpackage

// ==== hdl/npu_top.sv ====
`timescale 1ns/1ps

module npu_top
    import npu_pkg::*;
(
    input  logic        CLOCK_50,
    input  logic        reset,
    input  logic        psel,
    input  logic        penable,
    input  logic        pwrite,
    input  logic [11:0] paddr,
    input  logic [31:0] pwdata,
    output logic [31:0] prdata,
    output logic        pready,
    output logic        pslverr
);
    logic      hp_cmd_valid;
    logic      hp_cmd_ready;
    npu_inst_u hp_cmd_word;
    logic      eng_cmd_valid;
    logic      eng_cmd_ready;
    npu_inst_u eng_cmd_word;
    logic      fifo_empty;
    logic      engine_busy;

    npu_mem_if host_mem_if ();
    npu_mem_if eng_mem_if ();

    // producer
    npu_host_port u_host_port (
        .CLOCK_50    (CLOCK_50),
        .reset       (reset),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .prdata      (prdata),
        .pready      (pready),
        .pslverr     (pslverr),
        .host_mem    (host_mem_if.requester),
        .cmd_valid   (hp_cmd_valid),
        .cmd_ready   (hp_cmd_ready),
        .cmd_word    (hp_cmd_word),
        .fifo_empty  (fifo_empty),
        .engine_busy (engine_busy)
    );

    // buffer
    npu_cmd_fifo u_cmd_fifo (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .in_valid  (hp_cmd_valid),
        .in_ready  (hp_cmd_ready),
        .in_word   (hp_cmd_word),
        .out_valid (eng_cmd_valid),
        .out_ready (eng_cmd_ready),
        .out_word  (eng_cmd_word),
        .empty     (fifo_empty)
    );

    // consumer
    npu_matrix_engine u_engine (
        .CLOCK_50  (CLOCK_50),
        .reset     (reset),
        .cmd_valid (eng_cmd_valid),
        .cmd_ready (eng_cmd_ready),
        .cmd_word  (eng_cmd_word),
        .eng_mem   (eng_mem_if.requester),
        .busy      (engine_busy)
    );

    npu_data_mem u_data_mem (
        .CLOCK_50 (CLOCK_50),
        .host_mem (host_mem_if.memory),
        .eng_mem  (eng_mem_if.memory)
    );

endmodule

// ==== npu_top.f ====
+incdir+hdl
+incdir+tb
hdl/npu_pkg.sv
hdl/npu_mem_if.sv
hdl/npu_host_port.sv
hdl/npu_cmd_fifo.sv
hdl/npu_matrix_engine.sv
hdl/npu_data_mem.sv
hdl/npu_top.sv
tb/npu_tb.sv

// ==== tb/npu_tb_tasks.svh ====
`ifndef NPU_TB_TASKS_SVH
`define NPU_TB_TASKS_SVH

// ----------------------------------------------------------------------------
// apb driver
// ----------------------------------------------------------------------------

// one transfer, setup then access until pready, sampled 1 ns after the falling edge
task automatic apb_xfer(input logic wr, input logic [11:0] addr, input logic [31:0] wdata,
                        output logic [31:0] rdata, output logic err, output int waited);
    @(negedge CLOCK_50);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge CLOCK_50);
    penable = 1'b1;
    waited  = 0;
    #1;
    while (pready !== 1'b1) begin
        if (waited >= APB_WAIT_MAX) begin
            abort_run($sformatf("pready stayed low for %0d cycles at address %h",
                                waited, addr));
        end
        @(negedge CLOCK_50);
        #1;
        waited++;
    end
    rdata = prdata;
    err   = pslverr;
    @(negedge CLOCK_50);
    psel    = 1'b0;
    penable = 1'b0;
endtask

task automatic data_write(input int a, input logic [`NPU_DATA_W-1:0] val);
    logic [31:0] rdata;
    logic        err;
    int          waited;
    apb_xfer(1'b1, `NPU_APB_DATA_BASE + 12'(a), {16'b0, val}, rdata, err, waited);
endtask

task automatic data_read(input int a, output logic [`NPU_DATA_W-1:0] val);
    logic [31:0] rdata;
    logic        err;
    int          waited;
    apb_xfer(1'b0, `NPU_APB_DATA_BASE + 12'(a), '0, rdata, err, waited);
    val = rdata[`NPU_DATA_W-1:0];
endtask

task automatic read_status(output logic [31:0] stat);
    logic err;
    int   waited;
    apb_xfer(1'b0, `NPU_APB_STATUS, '0, stat, err, waited);
endtask

// lo word first, the hi write submits
task automatic submit_inst(input npu_inst_u inst);
    logic [31:0] rdata;
    logic        err;
    int          waited;
    apb_xfer(1'b1, `NPU_APB_INST_LO, inst[31:0], rdata, err, waited);
    apb_xfer(1'b1, `NPU_APB_INST_HI, inst[63:32], rdata, err, waited);
    stall_cycles += waited;
endtask

// poll status until neither queue nor engine holds work
task automatic wait_idle(input string name);
    logic [31:0] stat;
    int          polls;
    polls = 0;
    read_status(stat);
    while (stat[0] !== 1'b0) begin
        if (polls >= IDLE_POLL_MAX) begin
            abort_run($sformatf("%s: still busy after %0d status polls", name, polls));
        end
        read_status(stat);
        polls++;
    end
endtask

// ----------------------------------------------------------------------------
// compare tasks
// ----------------------------------------------------------------------------
task automatic check_word(input string name, input logic [`NPU_DATA_W-1:0] exp,
                          input logic [`NPU_DATA_W-1:0] act);
    if (act !== exp) begin
        err_count++;
        abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act));
    end
endtask

task automatic check_status(input string name, input logic exp_busy, input logic exp_reject,
                            input logic [3:0] exp_count, input logic [31:0] act);
    logic [7:0] exp;
    exp = {exp_count, 2'b00, exp_reject, exp_busy};
    if (act[7:0] !== exp) begin
        err_count++;
        abort_run($sformatf("[ERROR] %s: expected %h, actual %h", name, exp, act[7:0]));
    end
endtask

task automatic check_slverr(input string name, input logic exp, input logic act);
    if (act !== exp) begin
        err_count++;
        abort_run($sformatf("[ERROR] %s: expected %b, actual %b", name, exp, act));
    end
endtask

// whole memory against the model
task automatic compare_memory(input string name);
    logic [`NPU_DATA_W-1:0] val;
    for (int a = 0; a < 1024; a++) begin
        data_read(a, val);
        check_word($sformatf("%s word %h", name, a), model_mem[a], val);
    end
endtask

`endif

// ==== tb/npu_tb.sv ====
`timescale 1ns/1ps
`include "npu_defs.svh"

module npu_tb
    import npu_pkg::*;
();
    localparam int APB_WAIT_MAX  = 2000;
    localparam int IDLE_POLL_MAX = 1000;
    localparam int N_ADD         = 6;
    localparam int N_POOL        = 6;
    localparam int N_QUEUED      = 6;

    logic        CLOCK_50;
    logic        reset;
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [11:0] paddr;
    logic [31:0] pwdata;
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;

    logic [`NPU_DATA_W-1:0] model_mem [1024];
    logic [3:0]             done_cnt;
    int                     err_count;
    int                     stall_cycles;

    npu_top DUT (
        .CLOCK_50 (CLOCK_50),
        .reset    (reset),
        .psel     (psel),
        .penable  (penable),
        .pwrite   (pwrite),
        .paddr    (paddr),
        .pwdata   (pwdata),
        .prdata   (prdata),
        .pready   (pready),
        .pslverr  (pslverr)
    );

    initial CLOCK_50 = 1'b0;
    always #5 CLOCK_50 = ~CLOCK_50;

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Verification failed");
        $fatal(1);
    endtask

    `include "npu_tb_tasks.svh"

    // ------------------------------------------------------------------------
    // stimulus helpers and reference model
    // ------------------------------------------------------------------------
    function automatic int rand_below(input int n);
        return int'($urandom % n);
    endfunction

    function automatic npu_inst_u rand_add(input int min_dim, input int max_dim);
        npu_inst_u inst;
        inst            = '0;
        inst.add.opcode = `NPU_OP_ADD;
        inst.add.src1   = 10'(rand_below(1024));
        inst.add.src2   = 10'(rand_below(1024));
        inst.add.dest   = 10'(rand_below(1024));
        inst.add.rows   = 4'(min_dim + rand_below(max_dim - min_dim + 1));
        inst.add.cols   = 4'(min_dim + rand_below(max_dim - min_dim + 1));
        return inst;
    endfunction

    // window never larger than 3 or the matrix
    function automatic npu_inst_u rand_pool(input int min_dim, input int max_dim);
        npu_inst_u inst;
        int        rows;
        int        cols;
        inst               = '0;
        rows               = min_dim + rand_below(max_dim - min_dim + 1);
        cols               = min_dim + rand_below(max_dim - min_dim + 1);
        inst.pool.opcode   = `NPU_OP_POOL;
        inst.pool.src      = 10'(rand_below(1024));
        inst.pool.dest     = 10'(rand_below(1024));
        inst.pool.rows     = 4'(rows);
        inst.pool.cols     = 4'(cols);
        inst.pool.win_rows = 4'(1 + rand_below(rows < 3 ? rows : 3));
        inst.pool.win_cols = 4'(1 + rand_below(cols < 3 ? cols : 3));
        return inst;
    endfunction

    function automatic npu_inst_u bad_inst(input int kind);
        npu_inst_u inst;
        inst = rand_add(1, 8);
        case (kind)
            0: inst.add.opcode = 4'h3;
            1: inst.add.rows = '0;
            2: begin
                inst           = rand_pool(4, 8);
                inst.pool.cols = '0;
            end
            3: begin
                inst               = rand_pool(4, 8);
                inst.pool.win_cols = 4'd4;
            end
            default: begin
                inst               = rand_pool(4, 8);
                inst.pool.rows     = 4'd2;
                inst.pool.win_rows = 4'd3;
            end
        endcase
        return inst;
    endfunction

    // element sums wrap at 16 bits in row-major order
    task automatic model_add(input npu_inst_u inst);
        int n;
        n = inst.add.rows * inst.add.cols;
        for (int k = 0; k < n; k++) begin
            model_mem[(inst.add.dest + k) % 1024] = model_mem[(inst.add.src1 + k) % 1024]
                                                  + model_mem[(inst.add.src2 + k) % 1024];
        end
    endtask

    // non-overlapping windows with partial edge windows dropped
    task automatic model_pool(input npu_inst_u inst);
        int                     wr;
        int                     wc;
        int                     cols;
        int                     k;
        logic [`NPU_DATA_W-1:0] best;
        logic [`NPU_DATA_W-1:0] sample;
        wr   = inst.pool.win_rows;
        wc   = inst.pool.win_cols;
        cols = inst.pool.cols;
        k    = 0;
        for (int r = 0; r < inst.pool.rows / wr; r++) begin
            for (int c = 0; c < cols / wc; c++) begin
                best = '0;
                for (int i = 0; i < wr; i++) begin
                    for (int j = 0; j < wc; j++) begin
                        sample = model_mem[(inst.pool.src + (r * wr + i) * cols
                                            + c * wc + j) % 1024];
                        if (sample > best) begin
                            best = sample;
                        end
                    end
                end
                model_mem[(inst.pool.dest + k) % 1024] = best;
                k++;
            end
        end
    endtask

    task automatic apply_model(input npu_inst_u inst);
        if (inst.add.opcode == `NPU_OP_ADD) begin
            model_add(inst);
        end else begin
            model_pool(inst);
        end
        done_cnt++;
    endtask

    // ------------------------------------------------------------------------
    // test sequence
    // ------------------------------------------------------------------------
    initial begin
        npu_inst_u              inst;
        logic [31:0]            stat;
        logic [31:0]            rdata;
        logic                   err;
        int                     waited;
        int                     a;
        logic [`NPU_DATA_W-1:0] val;

        void'($urandom(38));
        reset        = 1'b1;
        psel         = 1'b0;
        penable      = 1'b0;
        pwrite       = 1'b0;
        paddr        = '0;
        pwdata       = '0;
        err_count    = 0;
        done_cnt     = '0;
        stall_cycles = 0;
        repeat (16) @(posedge CLOCK_50);
        @(negedge CLOCK_50);
        reset = 1'b0;
        if (pready !== 1'b0 || pslverr !== 1'b0) begin
            abort_run("pready or pslverr not low after reset");
        end
        read_status(stat);
        check_status("status after reset", 1'b0, 1'b0, 4'd0, stat);

        // fill the data window and overwrite scattered words
        for (int i = 0; i < 1024; i++) begin
            val          = 16'($urandom);
            model_mem[i] = val;
            data_write(i, val);
        end
        for (int i = 0; i < 200; i++) begin
            a            = rand_below(1024);
            val          = 16'($urandom);
            model_mem[a] = val;
            data_write(a, val);
        end
        compare_memory("data window");

        for (int i = 0; i < N_ADD; i++) begin
            inst = rand_add(1, 8);
            submit_inst(inst);
            apply_model(inst);
            wait_idle("add");
            read_status(stat);
            check_status("add status", 1'b0, 1'b0, done_cnt, stat);
            compare_memory("add");
        end

        for (int i = 0; i < N_POOL; i++) begin
            inst = rand_pool(1, 12);
            submit_inst(inst);
            apply_model(inst);
            wait_idle("pool");
            read_status(stat);
            check_status("pool status", 1'b0, 1'b0, done_cnt, stat);
            compare_memory("pool");
        end

        // a long first add keeps the engine busy so the queue fills
        stall_cycles = 0;
        for (int i = 0; i < N_QUEUED; i++) begin
            if (i % 2 == 0) begin
                inst = rand_add(4, 8);
            end else begin
                inst = rand_pool(6, 12);
            end
            submit_inst(inst);
            apply_model(inst);
        end
        if (stall_cycles == 0) begin
            abort_run("no instruction write stalled while the command queue was full");
        end
        wait_idle("queued");
        read_status(stat);
        check_status("queued status", 1'b0, 1'b0, done_cnt, stat);
        compare_memory("queued");

        for (int kind = 0; kind < 5; kind++) begin
            submit_inst(bad_inst(kind));
            read_status(stat);
            check_status($sformatf("reject %0d set", kind), 1'b0, 1'b1, done_cnt, stat);
            apb_xfer(1'b1, `NPU_APB_STATUS, 32'h2, rdata, err, waited);
            read_status(stat);
            check_status($sformatf("reject %0d clear", kind), 1'b0, 1'b0, done_cnt, stat);
        end
        compare_memory("reject");

        apb_xfer(1'b0, 12'h400 + 12'(rand_below(1024)), '0, rdata, err, waited);
        check_slverr("unmapped read", 1'b1, err);
        apb_xfer(1'b1, 12'h803 + 12'(rand_below(2045)), 32'hFFFF, rdata, err, waited);
        check_slverr("unmapped write", 1'b1, err);
        apb_xfer(1'b0, `NPU_APB_STATUS, '0, rdata, err, waited);
        check_slverr("status read", 1'b0, err);
        compare_memory("unmapped");

        if (err_count == 0) begin
            $display("Verification passed");
            $finish;
        end else begin
            abort_run("checks failed during the run");
        end
    end

endmodule
